/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      req_valid,
    input  logic      req_op,
    input  word_t     req_addr,
    input  word_t     req_wdata,
    input  byte_en_t  req_byte_en,
    input  exc_code_t req_exc,
    output logic      cache_ready,
    output logic      done,
    output word_t     hit_word,
    output logic      rd_req,
    output word_t     rd_addr,
    input  logic      rd_rdy,
    input  logic      ret_valid,
    input  logic      ret_last,
    input  word_t     ret_data,
    output logic      wr_req,
    output word_t     wr_addr,
    input  logic      wr_rdy,
    output logic      wr_valid,
    output logic      wr_last,
    output word_t     wr_data,
    input  logic      b_valid
);

    localparam int SETS = 1 << `DC_INDEX_BITS;
    localparam word_sel_t LAST_BEAT = word_sel_t'(`DC_LINE_WORDS - 1);

    cache_state_e    state, state_next;
    cache_tag_t      tag_arr [SETS];
    logic [SETS-1:0] valid_arr;
    logic [SETS-1:0] dirty_arr;
    word_t           data_arr [SETS][`DC_LINE_WORDS];
    word_t           line_buf [`DC_LINE_WORDS];
    word_sel_t       beat_cnt;

    cache_tag_t   req_tag;
    cache_index_t req_idx;
    word_sel_t    req_word;
    word_t        cur_word;
    logic         lookup, hit, exc_req, store_hit, refill_end;

    assign req_tag  = req_addr[31 -: `DC_TAG_BITS];
    assign req_idx  = req_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign req_word = req_addr[`DC_OFFSET_BITS-1 -: 2];

    // first lookup happens in the cycle after acceptance, still in IDLE
    assign lookup     = (state == IDLE && req_valid) || state == LOOKUP;
    assign exc_req    = req_exc != `DC_EXC_NONE;
    assign hit        = valid_arr[req_idx] && tag_arr[req_idx] == req_tag;
    assign done       = lookup && (exc_req || hit);
    assign store_hit  = done && !exc_req && req_op;
    assign refill_end = state == REFILL && ret_valid && ret_last;

    assign cache_ready = state == IDLE && !req_valid;

    // store merge under byte enables
    assign cur_word = data_arr[req_idx][req_word];
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            hit_word[8*b +: 8] = (req_op && req_byte_en[b]) ? req_wdata[8*b +: 8]
                                                            : cur_word[8*b +: 8];
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE, LOOKUP: begin
                if (lookup) begin
                    if (done)
                        state_next = IDLE;
                    else if (valid_arr[req_idx] && dirty_arr[req_idx])
                        state_next = WB_REQ;
                    else
                        state_next = RD_REQ;
                end
            end
            WB_REQ:  if (wr_rdy) state_next = WB_DATA;
            WB_DATA: if (beat_cnt == LAST_BEAT) state_next = WB_RESP;
            WB_RESP: if (b_valid) state_next = RD_REQ;
            RD_REQ:  if (rd_rdy) state_next = REFILL;
            REFILL:  if (refill_end) state_next = LOOKUP;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (wr_valid || (state == REFILL && ret_valid))
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // memory side, line aligned
    assign rd_req   = state == RD_REQ;
    assign rd_addr  = {req_tag, req_idx, {`DC_OFFSET_BITS{1'b0}}};
    assign wr_req   = state == WB_REQ;
    assign wr_addr  = {tag_arr[req_idx], req_idx, {`DC_OFFSET_BITS{1'b0}}};
    assign wr_valid = state == WB_DATA;
    assign wr_last  = wr_valid && beat_cnt == LAST_BEAT;
    assign wr_data  = data_arr[req_idx][beat_cnt];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else if (store_hit) begin
            dirty_arr[req_idx] <= 1'b1;
        end else if (refill_end) begin
            valid_arr[req_idx] <= 1'b1;
            dirty_arr[req_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit)
            data_arr[req_idx][req_word] <= hit_word;
        if (state == REFILL && ret_valid)
            line_buf[beat_cnt] <= ret_data;
        // last beat goes straight in with the buffered ones
        if (refill_end) begin
            tag_arr[req_idx] <= req_tag;
            for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                data_arr[req_idx][w] <= (word_sel_t'(w) == beat_cnt) ? ret_data : line_buf[w];
            end
        end
    end

endmodule

/* rtl/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// geometry
`define DC_INDEX_BITS   4
`define DC_OFFSET_BITS  4
`define DC_TAG_BITS     24
`define DC_LINE_WORDS   4

// access size codes
`define DC_SIZE_BYTE    2'd0
`define DC_SIZE_HALF    2'd1
`define DC_SIZE_WORD    2'd2

// exception codes
`define DC_EXC_NONE     7'h00
`define DC_EXC_ALE      7'h09

`endif

/* rtl/dcache_load_align.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_load_align
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      done,
    input  word_t     hit_word,
    input  logic      req_op,
    input  acc_size_t req_size,
    input  logic      req_signed,
    input  logic [1:0] req_addr,
    input  exc_code_t req_exc,
    output logic      data_valid,
    output word_t     rdata,
    output exc_code_t exception
);

    word_t shifted;
    word_t load_data;

    assign shifted = hit_word >> {req_addr, 3'b000};

    always_comb begin
        case (req_size)
            `DC_SIZE_BYTE: load_data = {{24{req_signed & shifted[7]}}, shifted[7:0]};
            `DC_SIZE_HALF: load_data = {{16{req_signed & shifted[15]}}, shifted[15:0]};
            default:       load_data = hit_word;
        endcase
        // stores and faulting requests return zero
        if (req_op || req_exc != `DC_EXC_NONE)
            load_data = '0;
    end

    always_ff @(posedge clk) begin
        if (reset)
            data_valid <= 1'b0;
        else
            data_valid <= done;
    end

    // output buffer
    always_ff @(posedge clk) begin
        rdata     <= done ? load_data : '0;
        exception <= done ? req_exc : `DC_EXC_NONE;
    end

endmodule

/* rtl/dcache_pkg.sv */
`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [31:0]                word_t;
    typedef logic [`DC_TAG_BITS-1:0]    cache_tag_t;
    typedef logic [`DC_INDEX_BITS-1:0]  cache_index_t;
    typedef logic [1:0]                 word_sel_t;
    typedef logic [3:0]                 byte_en_t;
    typedef logic [1:0]                 acc_size_t;
    typedef logic [6:0]                 exc_code_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_DATA,
        WB_RESP,
        RD_REQ,
        REFILL
    } cache_state_e;

endpackage

/* rtl/dcache_req_decode.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_req_decode
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      valid,
    input  logic      op,
    input  acc_size_t size,
    input  logic      signed_ext,
    input  word_t     addr,
    input  word_t     wdata,
    input  logic      cache_ready,
    output logic      req_valid,
    output logic      req_op,
    output acc_size_t req_size,
    output logic      req_signed,
    output word_t     req_addr,
    output word_t     req_wdata,
    output byte_en_t  req_byte_en,
    output exc_code_t req_exc
);

    logic      accept;
    byte_en_t  byte_en;
    word_t     lane_data;
    exc_code_t exc;

    assign accept = valid && cache_ready;

    // byte enables, lane replication and alignment check
    always_comb begin
        case (size)
            `DC_SIZE_BYTE: begin
                byte_en   = 4'b0001 << addr[1:0];
                lane_data = {4{wdata[7:0]}};
                exc       = `DC_EXC_NONE;
            end
            `DC_SIZE_HALF: begin
                byte_en   = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{wdata[15:0]}};
                exc       = addr[0] ? `DC_EXC_ALE : `DC_EXC_NONE;
            end
            default: begin
                byte_en   = 4'b1111;
                lane_data = wdata;
                exc       = (addr[1:0] != 2'b00) ? `DC_EXC_ALE : `DC_EXC_NONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;
        end
    end

    // request buffer, held until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            req_op      <= op;
            req_size    <= size;
            req_signed  <= signed_ext;
            req_addr    <= addr;
            req_wdata   <= lane_data;
            req_byte_en <= byte_en;
            req_exc     <= exc;
        end
    end

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // cpu side
    input  logic      valid,
    input  logic      op,
    input  acc_size_t size,
    input  logic      signed_ext,
    input  word_t     addr,
    input  word_t     wdata,
    output logic      cache_ready,
    output logic      data_valid,
    output word_t     rdata,
    output exc_code_t exception,
    // memory read
    output logic      rd_req,
    output word_t     rd_addr,
    input  logic      rd_rdy,
    input  logic      ret_valid,
    input  logic      ret_last,
    input  word_t     ret_data,
    // memory write
    output logic      wr_req,
    output word_t     wr_addr,
    input  logic      wr_rdy,
    output logic      wr_valid,
    output logic      wr_last,
    output word_t     wr_data,
    input  logic      b_valid
);

    logic      req_valid, req_op, req_signed, done;
    acc_size_t req_size;
    word_t     req_addr, req_wdata, hit_word;
    byte_en_t  req_byte_en;
    exc_code_t req_exc;

    dcache_req_decode u_decode (
        .clk(clk), .reset(reset), .valid(valid), .op(op), .size(size),
        .signed_ext(signed_ext), .addr(addr), .wdata(wdata), .cache_ready(cache_ready),
        .req_valid(req_valid), .req_op(req_op), .req_size(req_size),
        .req_signed(req_signed), .req_addr(req_addr), .req_wdata(req_wdata),
        .req_byte_en(req_byte_en), .req_exc(req_exc)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_op(req_op),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_byte_en(req_byte_en),
        .req_exc(req_exc), .cache_ready(cache_ready), .done(done), .hit_word(hit_word),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy), .ret_valid(ret_valid),
        .ret_last(ret_last), .ret_data(ret_data), .wr_req(wr_req), .wr_addr(wr_addr),
        .wr_rdy(wr_rdy), .wr_valid(wr_valid), .wr_last(wr_last), .wr_data(wr_data),
        .b_valid(b_valid)
    );

    dcache_load_align u_result (
        .clk(clk), .reset(reset), .done(done), .hit_word(hit_word), .req_op(req_op),
        .req_size(req_size), .req_signed(req_signed), .req_addr(req_addr[1:0]),
        .req_exc(req_exc), .data_valid(data_valid), .rdata(rdata), .exception(exception)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f tb.f -o dcache_sim

./obj_dir/dcache_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

/* tb.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_req_decode.sv
rtl/dcache_ctrl.sv
rtl/dcache_load_align.sv
rtl/dcache_top.sv
tb/dcache_assertions.sv
tb/dcache_tb.sv

/* tb/dcache_assertions.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_assertions
    import dcache_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input cache_state_e state,
    input logic         req_valid,
    input logic         done,
    input exc_code_t    req_exc,
    input logic         rd_req,
    input logic         rd_rdy,
    input logic         wr_req,
    input logic         wr_rdy,
    input logic         wr_valid,
    input logic         wr_last
);

    logic [1:0] beats;

    // write beat count wraps after each burst
    always_ff @(posedge clk) begin
        if (reset)
            beats <= '0;
        else if (wr_valid)
            beats <= beats + 1'b1;
    end

    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held for more than one cycle");

    rd_hold: assert property (@(posedge clk) disable iff (reset) rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    wr_hold: assert property (@(posedge clk) disable iff (reset) wr_req && !wr_rdy |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

    exc_quiet: assert property (@(posedge clk) disable iff (reset)
        (req_valid && req_exc != `DC_EXC_NONE) |=> (state == IDLE && !rd_req && !wr_req))
        else $error("memory request after a faulting request");

    last_beat: assert property (@(posedge clk) disable iff (reset)
        wr_valid |-> (wr_last == (beats == 2'd3)))
        else $error("wr_last not on the fourth write beat");

endmodule

bind dcache_ctrl dcache_assertions u_assert (
    .clk(clk), .reset(reset), .state(state), .req_valid(req_valid), .done(done),
    .req_exc(req_exc), .rd_req(rd_req), .rd_rdy(rd_rdy), .wr_req(wr_req), .wr_rdy(wr_rdy),
    .wr_valid(wr_valid), .wr_last(wr_last)
);

/* tb/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int        ld = 0;
    localparam int        st = 1;
    localparam acc_size_t sz_b = `DC_SIZE_BYTE;
    localparam acc_size_t sz_h = `DC_SIZE_HALF;
    localparam acc_size_t sz_w = `DC_SIZE_WORD;
    localparam exc_code_t no_exc = `DC_EXC_NONE;
    localparam exc_code_t ale = `DC_EXC_ALE;

    typedef struct packed {
        logic      op;
        acc_size_t size;
        logic      sgn;
        word_t     addr;
        word_t     wdata;
        word_t     exp_rdata;
        exc_code_t exp_exc;
        logic      exp_fixed;
    } stim_t;

    logic      clk, reset;
    logic      valid, op, signed_ext, cache_ready, data_valid;
    acc_size_t size;
    word_t     addr, wdata, rdata;
    exc_code_t exception;
    logic      rd_req, rd_rdy, ret_valid, ret_last;
    word_t     rd_addr, ret_data;
    logic      wr_req, wr_rdy, wr_valid, wr_last, b_valid;
    word_t     wr_addr, wr_data;

    word_t     mem [256];
    word_t     ref_mem [256];
    stim_t     table_q [$];
    int        errors, checks, rd_count, wr_count;

    dcache_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    function automatic word_t ref_load(input word_t a, input acc_size_t sz, input logic sgn);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_mem[a[9:2]];
        b = w[8*a[1:0] +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        if (sz == sz_b)
            return {{24{sgn && b[7]}}, b};
        if (sz == sz_h)
            return {{16{sgn && h[15]}}, h};
        return w;
    endfunction

    function automatic void ref_store(input word_t a, input acc_size_t sz, input word_t d);
        if (sz == sz_b)
            ref_mem[a[9:2]][8*a[1:0] +: 8] = d[7:0];
        else if (sz == sz_h)
            ref_mem[a[9:2]][16*a[1] +: 16] = d[15:0];
        else
            ref_mem[a[9:2]] = d;
    endfunction

    function automatic void add_row(input int o, input acc_size_t sz, input int sg,
                                    input word_t a, input word_t d, input word_t exp,
                                    input exc_code_t exc, input int fixed);
        stim_t s;
        s = '{o != 0, sz, sg != 0, a, d, exp, exc, fixed != 0};
        table_q.push_back(s);
    endfunction

    task automatic fill_table();
        acc_size_t sz;
        word_t     a;
        // cold miss followed by the rest of the line
        add_row(ld, sz_w, 0, 32'h040, 0, 32'h0010_ffef, no_exc, 1);
        add_row(ld, sz_w, 0, 32'h044, 0, 32'h0011_ffee, no_exc, 1);
        add_row(ld, sz_h, 0, 32'h046, 0, 32'h0000_0011, no_exc, 1);
        add_row(ld, sz_b, 0, 32'h045, 0, 32'h0000_00ff, no_exc, 1);
        // sign and zero extension
        add_row(ld, sz_h, 1, 32'h044, 0, 32'hffff_ffee, no_exc, 1);
        add_row(ld, sz_h, 0, 32'h044, 0, 32'h0000_ffee, no_exc, 1);
        add_row(ld, sz_b, 1, 32'h044, 0, 32'hffff_ffee, no_exc, 1);
        add_row(ld, sz_b, 1, 32'h046, 0, 32'h0000_0011, no_exc, 1);
        add_row(ld, sz_b, 1, 32'h045, 0, 32'hffff_ffff, no_exc, 1);
        // partial stores merged into one word
        add_row(st, sz_b, 0, 32'h049, 32'h0000_00a5, 0, no_exc, 1);
        add_row(st, sz_h, 0, 32'h04a, 32'h0000_8001, 0, no_exc, 1);
        add_row(ld, sz_w, 0, 32'h048, 0, 32'h8001_a5ed, no_exc, 1);
        add_row(st, sz_w, 0, 32'h04c, 32'hdead_beef, 0, no_exc, 1);
        add_row(ld, sz_h, 1, 32'h04e, 0, 32'hffff_dead, no_exc, 1);
        add_row(ld, sz_b, 1, 32'h049, 0, 32'hffff_ffa5, no_exc, 1);
        add_row(ld, sz_h, 0, 32'h04a, 0, 32'h0000_8001, no_exc, 1);
        // misaligned
        add_row(ld, sz_h, 0, 32'h041, 0, 0, ale, 1);
        add_row(st, sz_w, 0, 32'h102, 32'h1111_2222, 0, ale, 1);
        add_row(ld, sz_w, 0, 32'h203, 0, 0, ale, 1);
        // dirty victim has to go out before the refill
        add_row(st, sz_w, 0, 32'h080, 32'h1234_5678, 0, no_exc, 1);
        add_row(ld, sz_w, 0, 32'h180, 0, 32'h0060_ff9f, no_exc, 1);
        add_row(ld, sz_w, 0, 32'h080, 0, 32'h1234_5678, no_exc, 1);
        // random traffic over 64 words with four tags per index
        for (int i = 0; i < 40; i++) begin
            sz = acc_size_t'($urandom_range(2, 0));
            a  = ($urandom_range(3, 0) << 8) | ($urandom_range(3, 0) << 4)
               | ($urandom_range(3, 0) << 2);
            if (sz == sz_b)
                a[1:0] = 2'($urandom_range(3, 0));
            else if (sz == sz_h)
                a[1] = 1'($urandom_range(1, 0));
            add_row($urandom_range(1, 0), sz, $urandom_range(1, 0), a, $urandom, 0, no_exc, 0);
        end
    endtask

    task automatic apply_request(input stim_t s, input int n);
        int    waited;
        int    mem_reqs;
        int    err0;
        word_t exp_data;
        err0     = errors;
        mem_reqs = rd_count + wr_count;
        exp_data = s.exp_fixed ? s.exp_rdata : (s.op ? 32'h0 : ref_load(s.addr, s.size, s.sgn));
        waited = 0;
        while (!cache_ready && waited < 200) begin
            step();
            waited++;
        end
        if (!cache_ready) begin
            errors++;
            $display("test %0d: timed out waiting for cache_ready", n);
            return;
        end
        valid      = 1'b1;
        op         = s.op;
        size       = s.size;
        signed_ext = s.sgn;
        addr       = s.addr;
        wdata      = s.wdata;
        step();
        valid  = 1'b0;
        waited = 0;
        while (!data_valid && waited < 200) begin
            step();
            waited++;
        end
        if (!data_valid) begin
            errors++;
            $display("test %0d: timed out waiting for data_valid", n);
            return;
        end
        check_value("rdata", rdata, exp_data);
        check_value("exception", word_t'(exception), word_t'(s.exp_exc));
        if (s.exp_exc != no_exc) begin
            check_value("response latency", word_t'(waited), 32'h1);
            check_value("memory requests", word_t'(rd_count + wr_count), word_t'(mem_reqs));
        end else if (s.op) begin
            ref_store(s.addr, s.size, s.wdata);
        end else if (s.exp_fixed) begin
            check_value("rdata vs reference", rdata, ref_load(s.addr, s.size, s.sgn));
        end
        $display("test %0d: %s size %0d addr %h %s", n, s.op ? "store" : "load", s.size,
                 s.addr, errors == err0 ? "ok" : "mismatch");
    endtask

    // memory read port answering refills with random gaps
    initial begin : read_port
        logic [7:0] base;
        forever begin
            @(negedge clk);
            if (rd_req) begin
                rd_count++;
                base = rd_addr[9:2];
                step();
                repeat ($urandom_range(3, 0)) step();
                rd_rdy = 1'b1;
                step();
                rd_rdy = 1'b0;
                for (int b = 0; b < 4; b++) begin
                    repeat ($urandom_range(3, 0)) step();
                    ret_valid = 1'b1;
                    ret_last  = (b == 3);
                    ret_data  = mem[base + b];
                    step();
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

    // memory write port taking back to back beats
    initial begin : write_port
        logic [7:0] base;
        forever begin
            @(negedge clk);
            if (wr_req) begin
                wr_count++;
                base = wr_addr[9:2];
                step();
                repeat ($urandom_range(3, 0)) step();
                wr_rdy = 1'b1;
                step();
                wr_rdy = 1'b0;
                for (int b = 0; b < 4; b++) begin
                    @(negedge clk);
                    check_value("wr_valid", word_t'(wr_valid), 32'h1);
                    check_value("wr_last", word_t'(wr_last), word_t'(b == 3));
                    mem[base + b] = wr_data;
                end
                step();
                repeat ($urandom_range(3, 0)) step();
                b_valid = 1'b1;
                step();
                b_valid = 1'b0;
            end
        end
    end

    initial begin : main
        word_t w;
        void'($urandom(32'hd17f6670));
        errors     = 0;
        checks     = 0;
        rd_count   = 0;
        wr_count   = 0;
        reset      = 1'b1;
        valid      = 1'b0;
        op         = 1'b0;
        size       = sz_w;
        signed_ext = 1'b0;
        addr       = '0;
        wdata      = '0;
        rd_rdy     = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        ret_data   = '0;
        wr_rdy     = 1'b0;
        b_valid    = 1'b0;
        // word address on top and its inverse below
        for (int i = 0; i < 256; i++) begin
            w          = i;
            mem[i]     = {w[15:0], ~w[15:0]};
            ref_mem[i] = mem[i];
        end
        fill_table();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("cache_ready", word_t'(cache_ready), 32'h1);
        check_value("data_valid", word_t'(data_valid), 32'h0);
        check_value("rd_req", word_t'(rd_req), 32'h0);
        check_value("wr_req", word_t'(wr_req), 32'h0);
        check_value("wr_valid", word_t'(wr_valid), 32'h0);
        foreach (table_q[n])
            apply_request(table_q[n], n);
        check_value("memory word 0x20", mem[8'h20], 32'h1234_5678);
        $display("%0d tests, %0d checks, %0d errors", table_q.size(), checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
